/* rtl/riscv_pkg.sv */
`default_nettype none
// RISC-V vector ISA encodings used by the fixed-point unit
// Element width (vsew) and fixed-point rounding mode (vxrm)

package riscv_pkg;

    // Selected element width, vsew encoding
    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_t;

    // Fixed-point rounding mode, vxrm CSR encoding
    typedef enum logic [1:0] {
        RNU_V = 2'd0,   // Round to nearest, ties up
        RNE_V = 2'd1,   // Round to nearest, ties to even
        RDN_V = 2'd2,   // Round down, truncate
        ROD_V = 2'd3    // Round to odd, jam
    } vxrm_t;

endpackage

`default_nettype wire

/* rtl/drac_pkg.sv */
`default_nettype none
// Core microarchitecture types for the vector lane cluster
// Data word, fixed-point instruction types and default cluster sizes

package drac_pkg;

    // Cluster sizes used as top-level parameter defaults
    localparam int DEF_NUM_LANES   = 4;    // 64-bit lanes per request
    localparam int DEF_QUEUE_DEPTH = 4;    // Issue queue entries, equal to upstream credits
    localparam int DEF_OUT_CREDITS = 2;    // Downstream credits held after reset

    // One lane data word
    typedef logic [63:0] bus64_t;

    // Fixed-point add/subtract instructions handled by the unit
    typedef enum logic [3:0] {
        VSADDU = 4'd0,  // Saturating add, unsigned
        VSADD  = 4'd1,  // Saturating add, signed
        VSSUBU = 4'd2,  // Saturating subtract, unsigned
        VSSUB  = 4'd3,  // Saturating subtract, signed
        VAADDU = 4'd4,  // Averaging add, unsigned
        VAADD  = 4'd5,  // Averaging add, signed
        VASUBU = 4'd6,  // Averaging subtract, unsigned
        VASUB  = 4'd7   // Averaging subtract, signed
    } instr_type_t;

endpackage

`default_nettype wire

/* rtl/vsaaddsub.sv */
`timescale 1ns/1ns
`default_nettype none
// One 64-bit lane of saturating and averaging add/subtract
// Eight byte adders chained by SEW, with per-element saturation and vxrm rounding

module vsaaddsub
    import drac_pkg::*;
    import riscv_pkg::*;
(
    input  instr_type_t instr_type_i,   // Instruction type
    input  sew_t        sew_i,          // Element width
    input  vxrm_t       vxrm_i,         // Rounding mode for averaging ops
    input  bus64_t      data_vs1_i,     // Source operand 1
    input  bus64_t      data_vs2_i,     // Source operand 2
    output bus64_t      data_vd_o,      // Result word
    output logic        sat_ovf_o       // Some element saturated
);

    logic            is_sub;
    logic            is_signed;
    logic            is_avg;
    logic [2:0]      byte_mask;     // Byte index bits that stay inside one element
    logic [7:0]      elem_low;      // Byte is the lowest of its element
    logic [7:0]      elem_top;      // Byte is the highest of its element

    bus64_t          op_a;
    bus64_t          op_b;
    bus64_t          sum_w;         // Raw byte adder outputs
    bus64_t          shift_w;       // Full-precision result shifted right by one
    logic [7:0]      carry_out;
    logic [7:0]      ext_bit;       // Bit SEW of the full-precision result
    logic [7:0]      ovf_top;       // Overflow, valid on top bytes only
    logic [7:0]      ovf_elem;      // Overflow spread over the whole element
    logic [7:0][7:0] sat_b;
    logic [7:0][7:0] avg_b;

    // Rounding increment for a right shift by one
    function automatic logic round_inc(vxrm_t mode, logic [1:0] v);
        case (mode)
            RNU_V:   round_inc = v[0];
            RNE_V:   round_inc = v[0] & v[1];
            RDN_V:   round_inc = 1'b0;
            default: round_inc = v[0] & ~v[1];  // ROD
        endcase
    endfunction

    assign is_sub    = instr_type_i inside {VSSUBU, VSSUB, VASUBU, VASUB};
    assign is_signed = instr_type_i inside {VSADD, VSSUB, VAADD, VASUB};
    assign is_avg    = instr_type_i inside {VAADDU, VAADD, VASUBU, VASUB};

    always_comb begin
        case (sew_i)
            SEW_8:   byte_mask = 3'b000;
            SEW_16:  byte_mask = 3'b001;
            SEW_32:  byte_mask = 3'b011;
            default: byte_mask = 3'b111;    // SEW_64
        endcase
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            elem_low[i] = (3'(i) & byte_mask) == 3'b000;
            elem_top[i] = (3'(i) & byte_mask) == byte_mask;
        end
    end

    // vs2 - vs1 is vs2 + ~vs1 + 1
    assign op_a = is_sub ? ~data_vs1_i : data_vs1_i;
    assign op_b = data_vs2_i;

    // Byte adders, carry passes on only inside an element
    always_comb begin
        logic carry;
        carry = is_sub;
        for (int i = 0; i < 8; i++) begin
            if (elem_low[i]) begin
                carry = is_sub;
            end
            {carry_out[i], sum_w[8*i +: 8]} = op_a[8*i +: 8] + op_b[8*i +: 8] + 9'(carry);
            carry = carry_out[i];
        end
    end

    // Overflow and extension bit per element top byte
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            // Sign-extended or zero-extended operands give the extra result bit
            ext_bit[i] = (is_signed ? op_a[8*i+7] ^ op_b[8*i+7] : is_sub) ^ carry_out[i];
            if (is_signed) begin
                // Same operand signs and a result of the other sign
                ovf_top[i] = (op_a[8*i+7] ^ sum_w[8*i+7]) & (op_b[8*i+7] ^ sum_w[8*i+7]);
            end else begin
                ovf_top[i] = carry_out[i] ^ is_sub;     // Carry on add, borrow on sub
            end
            ovf_top[i] = ovf_top[i] & elem_top[i] & ~is_avg;
        end
    end

    // Walk down from each top byte to spread overflow and the clamp value
    always_comb begin
        logic ovf;
        logic neg;
        ovf = 1'b0;
        neg = 1'b0;
        for (int i = 7; i >= 0; i--) begin
            if (elem_top[i]) begin
                ovf = ovf_top[i];
                neg = is_signed ? op_b[8*i+7] : is_sub;   // Clamp to min / zero
            end
            ovf_elem[i] = ovf;
            if (is_signed && elem_top[i]) begin
                sat_b[i] = {neg, {7{~neg}}};
            end else begin
                sat_b[i] = {8{~neg}};
            end
        end
    end

    always_comb begin
        shift_w = sum_w >> 1;
        for (int i = 0; i < 8; i++) begin
            if (elem_top[i]) begin
                shift_w[8*i+7] = ext_bit[i];
            end
        end
    end

    // Second byte chain adds the rounding increment at each element's low byte
    always_comb begin
        logic carry;
        carry = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (elem_low[i]) begin
                carry = round_inc(vxrm_i, sum_w[8*i +: 2]);
            end
            {carry, avg_b[i]} = shift_w[8*i +: 8] + 9'(carry);
        end
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            if (is_avg) begin
                data_vd_o[8*i +: 8] = avg_b[i];
            end else if (ovf_elem[i]) begin
                data_vd_o[8*i +: 8] = sat_b[i];
            end else begin
                data_vd_o[8*i +: 8] = sum_w[8*i +: 8];
            end
        end
    end

    assign sat_ovf_o = |ovf_top;

endmodule

`default_nettype wire

/* rtl/vfxp_issue_queue.sv */
`timescale 1ns/1ns
`default_nettype none
// Issue queue of the fixed-point unit
// Circular FIFO filled under upstream credits, one credit returned per pop

module vfxp_issue_queue
    import drac_pkg::*;
    import riscv_pkg::*;
#(
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH,
    parameter int NUM_LANES   = DEF_NUM_LANES
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   req_valid_i,
    input  instr_type_t            req_instr_i,
    input  sew_t                   req_sew_i,
    input  vxrm_t                  req_vxrm_i,
    input  bus64_t [NUM_LANES-1:0] req_vs1_i,
    input  bus64_t [NUM_LANES-1:0] req_vs2_i,
    input  logic                   pop_i,          // Head leaves this cycle
    output logic                   head_valid_o,
    output instr_type_t            head_instr_o,
    output sew_t                   head_sew_o,
    output vxrm_t                  head_vxrm_o,
    output bus64_t [NUM_LANES-1:0] head_vs1_o,
    output bus64_t [NUM_LANES-1:0] head_vs2_o,
    output logic                   req_credit_o    // One upstream credit back
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] qptr_t;
    typedef logic [CNT_W-1:0] qcnt_t;

    instr_type_t            instr_q [QUEUE_DEPTH];
    sew_t                   sew_q   [QUEUE_DEPTH];
    vxrm_t                  vxrm_q  [QUEUE_DEPTH];
    bus64_t [NUM_LANES-1:0] vs1_q   [QUEUE_DEPTH];
    bus64_t [NUM_LANES-1:0] vs2_q   [QUEUE_DEPTH];

    qptr_t wr_ptr;
    qptr_t rd_ptr;
    qcnt_t count;

    function automatic qptr_t ptr_inc(qptr_t p);
        ptr_inc = (p == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Entry storage, sender holds a credit so a slot is always free
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            instr_q[wr_ptr] <= req_instr_i;
            sew_q[wr_ptr]   <= req_sew_i;
            vxrm_q[wr_ptr]  <= req_vxrm_i;
            vs1_q[wr_ptr]   <= req_vs1_i;
            vs2_q[wr_ptr]   <= req_vs2_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            req_credit_o <= 1'b0;
        end else begin
            if (req_valid_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count        <= count + qcnt_t'(req_valid_i) - qcnt_t'(pop_i);
            req_credit_o <= pop_i;      // Freed slot goes back upstream
        end
    end

    // Oldest entry
    assign head_valid_o = (count != '0);
    assign head_instr_o = instr_q[rd_ptr];
    assign head_sew_o   = sew_q[rd_ptr];
    assign head_vxrm_o  = vxrm_q[rd_ptr];
    assign head_vs1_o   = vs1_q[rd_ptr];
    assign head_vs2_o   = vs2_q[rd_ptr];

endmodule

`default_nettype wire

/* rtl/vfxp_writeback.sv */
`timescale 1ns/1ns
`default_nettype none
// Writeback of the fixed-point unit
// Two-entry result buffer sent under downstream credits, sticky vxsat

module vfxp_writeback
    import drac_pkg::*;
#(
    parameter int NUM_LANES   = DEF_NUM_LANES,
    parameter int OUT_CREDITS = DEF_OUT_CREDITS
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   head_valid_i,   // Queue holds a request
    input  bus64_t [NUM_LANES-1:0] lane_vd_i,
    input  logic [NUM_LANES-1:0]   lane_sat_i,
    input  logic                   res_credit_i,   // Credit back from downstream
    input  logic                   vxsat_clr_i,
    output logic                   pop_o,
    output logic                   res_valid_o,
    output bus64_t [NUM_LANES-1:0] res_data_o,
    output logic                   res_sat_o,
    output logic                   vxsat_o
);

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    typedef logic [CRED_W-1:0] credit_t;

    bus64_t [NUM_LANES-1:0] buf_data [2];
    logic                   buf_sat  [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] buf_count;      // Occupied slots, 0 to 2
    credit_t    credits;        // Downstream credits on hand
    logic       send;

    assign pop_o = head_valid_i && (buf_count != 2'd2);
    assign send  = (buf_count != 2'd0) && (credits != '0);

    assign res_valid_o = send;
    assign res_data_o  = buf_data[rd_ptr];
    assign res_sat_o   = buf_sat[rd_ptr];

    // Lane outputs are taken at the edge of the pop
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            buf_data[wr_ptr] <= lane_vd_i;
            buf_sat[wr_ptr]  <= |lane_sat_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr    <= 1'b0;
            rd_ptr    <= 1'b0;
            buf_count <= 2'd0;
            credits   <= credit_t'(OUT_CREDITS);
            vxsat_o   <= 1'b0;
        end else begin
            if (pop_o) begin
                wr_ptr <= ~wr_ptr;
            end
            if (send) begin
                rd_ptr <= ~rd_ptr;
            end
            buf_count <= buf_count + {1'b0, pop_o} - {1'b0, send};
            credits   <= credits + credit_t'(res_credit_i) - credit_t'(send);

            // A set in the same cycle as a clear wins
            if (send && res_sat_o) begin
                vxsat_o <= 1'b1;
            end else if (vxsat_clr_i) begin
                vxsat_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/vfxp_unit.sv */
`timescale 1ns/1ns
`default_nettype none
// Fixed-point add/subtract unit of the vector lane cluster
// Issue queue feeding NUM_LANES combinational lanes and a writeback buffer

module vfxp_unit
    import drac_pkg::*;
    import riscv_pkg::*;
#(
    parameter int NUM_LANES   = DEF_NUM_LANES,
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH,
    parameter int OUT_CREDITS = DEF_OUT_CREDITS
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    // Upstream, credit based
    input  logic                   req_valid_i,
    input  instr_type_t            req_instr_i,
    input  sew_t                   req_sew_i,
    input  vxrm_t                  req_vxrm_i,
    input  bus64_t [NUM_LANES-1:0] req_vs1_i,
    input  bus64_t [NUM_LANES-1:0] req_vs2_i,
    output logic                   req_credit_o,
    // Downstream, credit based
    output logic                   res_valid_o,
    output bus64_t [NUM_LANES-1:0] res_data_o,
    output logic                   res_sat_o,
    input  logic                   res_credit_i,
    input  logic                   vxsat_clr_i,
    output logic                   vxsat_o         // Sticky saturation flag
);

    logic                   head_valid;
    instr_type_t            head_instr;
    sew_t                   head_sew;
    vxrm_t                  head_vxrm;
    bus64_t [NUM_LANES-1:0] head_vs1;
    bus64_t [NUM_LANES-1:0] head_vs2;
    bus64_t [NUM_LANES-1:0] lane_vd;
    logic [NUM_LANES-1:0]   lane_sat;
    logic                   pop;

    vfxp_issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .NUM_LANES   (NUM_LANES)
    ) issue_queue_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_instr_i  (req_instr_i),
        .req_sew_i    (req_sew_i),
        .req_vxrm_i   (req_vxrm_i),
        .req_vs1_i    (req_vs1_i),
        .req_vs2_i    (req_vs2_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_instr_o (head_instr),
        .head_sew_o   (head_sew),
        .head_vxrm_o  (head_vxrm),
        .head_vs1_o   (head_vs1),
        .head_vs2_o   (head_vs2),
        .req_credit_o (req_credit_o)
    );

    // One lane per 64-bit word, all sharing the head instruction
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        vsaaddsub lane_i (
            .instr_type_i (head_instr),
            .sew_i        (head_sew),
            .vxrm_i       (head_vxrm),
            .data_vs1_i   (head_vs1[k]),
            .data_vs2_i   (head_vs2[k]),
            .data_vd_o    (lane_vd[k]),
            .sat_ovf_o    (lane_sat[k])
        );
    end

    vfxp_writeback #(
        .NUM_LANES   (NUM_LANES),
        .OUT_CREDITS (OUT_CREDITS)
    ) writeback_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .head_valid_i (head_valid),
        .lane_vd_i    (lane_vd),
        .lane_sat_i   (lane_sat),
        .res_credit_i (res_credit_i),
        .vxsat_clr_i  (vxsat_clr_i),
        .pop_o        (pop),
        .res_valid_o  (res_valid_o),
        .res_data_o   (res_data_o),
        .res_sat_o    (res_sat_o),
        .vxsat_o      (vxsat_o)
    );

endmodule

`default_nettype wire

/* dv/vfxp_unit_properties.sv */
`timescale 1ns/1ns
`default_nettype none
// Credit, reset and queue occupancy properties of the fixed-point unit

module vfxp_unit_properties #(
    parameter int OUT_CREDITS = 2
) (
    input logic clk_i,
    input logic arst_n_i,
    input logic req_valid_i,
    input logic req_credit_i,
    input logic res_valid_i,
    input logic res_credit_i,
    input logic pop_i
);

    int out_credits;    // Downstream credits the unit holds
    int queued;         // Requests accepted and not yet popped

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_credits <= OUT_CREDITS;
        end else begin
            out_credits <= out_credits + int'(res_credit_i) - int'(res_valid_i);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            queued <= 0;
        end else begin
            queued <= queued + int'(req_valid_i) - int'(pop_i);
        end
    end

    quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !req_credit_i && !res_valid_i)
        else $error("Credit or result output active during reset");

    send_needs_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_credits == 0 |-> !res_valid_i)
        else $error("Result sent with no downstream credit");

    pop_needs_entry: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop_i |-> queued > 0)
        else $error("Queue popped while empty");

endmodule

`default_nettype wire

/* dv/vfxp_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none
// Testbench for the fixed-point add/subtract unit
// Random requests under credits, reference model, scoreboard and sticky vxsat tracking

module vfxp_unit_tb
    import drac_pkg::*;
    import riscv_pkg::*;
();

    localparam int NUM_LANES      = DEF_NUM_LANES;
    localparam int QUEUE_DEPTH    = DEF_QUEUE_DEPTH;
    localparam int OUT_CREDITS    = DEF_OUT_CREDITS;
    localparam int NUM_REQ        = 400;
    localparam int AVG_START      = 380;    // Averaging-only traffic from here on
    localparam int CLR_AT         = 392;    // Request that goes out with the vxsat clear
    localparam int SEED           = 97;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 8 + 200;

    typedef bus64_t [NUM_LANES-1:0] lanes_t;

    logic        clk_i;
    logic        arst_n_i;
    logic        req_valid_i;
    instr_type_t req_instr_i;
    sew_t        req_sew_i;
    vxrm_t       req_vxrm_i;
    lanes_t      req_vs1_i;
    lanes_t      req_vs2_i;
    logic        req_credit_o;
    logic        res_valid_o;
    lanes_t      res_data_o;
    logic        res_sat_o;
    logic        res_credit_i;
    logic        vxsat_clr_i;
    logic        vxsat_o;

    logic        run_en;
    logic        exp_vxsat = 1'b0;
    int          sent = 0;
    int          received = 0;
    int          credit_pulses = 0;
    int          owed = 0;              // Downstream credits not yet given back
    int          cycles = 0;
    int          value_errs = 0;
    int          flag_errs = 0;
    int          protocol_errs = 0;

    lanes_t      exp_data_q[$];
    logic        exp_sat_q[$];
    string       name_q[$];

    vfxp_unit vfxp_unit_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_instr_i  (req_instr_i),
        .req_sew_i    (req_sew_i),
        .req_vxrm_i   (req_vxrm_i),
        .req_vs1_i    (req_vs1_i),
        .req_vs2_i    (req_vs2_i),
        .req_credit_o (req_credit_o),
        .res_valid_o  (res_valid_o),
        .res_data_o   (res_data_o),
        .res_sat_o    (res_sat_o),
        .res_credit_i (res_credit_i),
        .vxsat_clr_i  (vxsat_clr_i),
        .vxsat_o      (vxsat_o)
    );

    bind vfxp_unit vfxp_unit_properties #(.OUT_CREDITS(OUT_CREDITS)) props_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_credit_i (req_credit_o),
        .res_valid_i  (res_valid_o),
        .res_credit_i (res_credit_i),
        .pop_i        (pop)
    );

    // Operand word biased toward values that overflow
    function automatic bus64_t rand_word();
        case ($urandom_range(0, 7))
            0:       rand_word = '1;
            1:       rand_word = 64'h8080_8080_8080_8080;
            2:       rand_word = 64'h7f7f_7f7f_7f7f_7f7f;
            default: rand_word = {$urandom(), $urandom()};
        endcase
    endfunction

    // Reference result of one word as {sat, data} with elements at full precision
    function automatic logic [64:0] model_word(instr_type_t op, sew_t sew, vxrm_t rm,
                                               bus64_t vs1, bus64_t vs2);
        int          w;
        logic        sgn;
        logic        sub;
        logic        avg;
        logic        sat;
        logic        r;
        logic [65:0] mask;
        logic [65:0] smax;
        logic [65:0] a;
        logic [65:0] b;
        logic [65:0] d;
        logic [65:0] res;
        bus64_t      out;
        w    = 8 << sew;
        sgn  = op inside {VSADD, VSSUB, VAADD, VASUB};
        sub  = op inside {VSSUBU, VSSUB, VASUBU, VASUB};
        avg  = op inside {VAADDU, VAADD, VASUBU, VASUB};
        mask = (66'd1 << w) - 66'd1;
        smax = mask >> 1;
        sat  = 1'b0;
        out  = '0;
        for (int i = 0; i < 64 / w; i++) begin
            a = {2'b00, vs2 >> (i * w)} & mask;
            b = {2'b00, vs1 >> (i * w)} & mask;
            if (sgn && a[w-1]) begin
                a = a | ~mask;
            end
            if (sgn && b[w-1]) begin
                b = b | ~mask;
            end
            d = sub ? a - b : a + b;    // vs2 - vs1 or vs2 + vs1
            if (avg) begin
                case (rm)
                    RNU_V:   r = d[0];
                    RNE_V:   r = d[0] & d[1];
                    RDN_V:   r = 1'b0;
                    default: r = d[0] & ~d[1];
                endcase
                res = $signed(d) >>> 1;
                res = res + 66'(r);
            end else if (sgn && $signed(d) > $signed(smax)) begin
                res = smax;
                sat = 1'b1;
            end else if (sgn && $signed(d) < $signed(~smax)) begin
                res = ~smax;
                sat = 1'b1;
            end else if (!sgn && (sub ? d[65] : d > mask)) begin
                res = sub ? '0 : mask;  // Borrow clamps to zero, carry to all ones
                sat = 1'b1;
            end else begin
                res = d;
            end
            out = out | ((res[63:0] & mask[63:0]) << (i * w));
        end
        model_word = {sat, out};
    endfunction

    function automatic void expect_request(input instr_type_t op, input sew_t sew,
                                           input vxrm_t rm,
                                           input lanes_t vs1, input lanes_t vs2,
                                           output lanes_t vd, output logic sat);
        logic [64:0] word;
        sat = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            word  = model_word(op, sew, rm, vs1[k], vs2[k]);
            vd[k] = word[63:0];
            sat   = sat | word[64];
        end
    endfunction

    task automatic report_counts();
        $display("Errors: value %0d, flag %0d, protocol %0d (%0d of %0d results)",
                 value_errs, flag_errs, protocol_errs, received, NUM_REQ);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Upstream sender spends one credit per request
    always @(posedge clk_i) begin : upstream_drv
        instr_type_t op;
        sew_t        sew;
        vxrm_t       rm;
        lanes_t      vs1;
        lanes_t      vs2;
        lanes_t      vd;
        logic        sat;
        if (run_en) begin
            if (req_credit_o) begin
                credit_pulses++;
            end
            assert (sent - credit_pulses >= 0 && sent - credit_pulses <= QUEUE_DEPTH) else begin
                protocol_errs++;
                $display("Upstream outstanding count %0d is outside 0 to %0d",
                         sent - credit_pulses, QUEUE_DEPTH);
            end
            req_valid_i <= 1'b0;
            vxsat_clr_i <= 1'b0;
            if (sent < NUM_REQ && sent - credit_pulses < QUEUE_DEPTH &&
                $urandom_range(0, 3) != 0) begin
                op  = instr_type_t'(4'($urandom_range(sent >= AVG_START ? 4 : 0, 7)));
                sew = sew_t'(2'($urandom_range(0, 3)));
                rm  = vxrm_t'(2'($urandom_range(0, 3)));
                for (int k = 0; k < NUM_LANES; k++) begin
                    vs1[k] = rand_word();
                    vs2[k] = rand_word();
                end
                expect_request(op, sew, rm, vs1, vs2, vd, sat);
                exp_data_q.push_back(vd);
                exp_sat_q.push_back(sat);
                name_q.push_back($sformatf("%s %s %s req %0d",
                                           op.name(), sew.name(), rm.name(), sent));
                req_valid_i <= 1'b1;
                req_instr_i <= op;
                req_sew_i   <= sew;
                req_vxrm_i  <= rm;
                req_vs1_i   <= vs1;
                req_vs2_i   <= vs2;
                vxsat_clr_i <= (sent == CLR_AT);
                sent++;
            end
        end
    end

    // Scoreboard and downstream credit return
    always @(posedge clk_i) begin : downstream_chk
        lanes_t exp_vd;
        logic   exp_sat;
        string  name;
        if (run_en) begin
            assert (vxsat_o == exp_vxsat) else begin
                flag_errs++;
                $display("Fail vxsat after %0d results: expected %0b actual %0b",
                         received, exp_vxsat, vxsat_o);
            end
            if (res_valid_o && res_sat_o) begin
                exp_vxsat = 1'b1;
            end else if (vxsat_clr_i) begin
                exp_vxsat = 1'b0;
            end
            if (res_valid_o) begin
                owed++;
                assert (exp_data_q.size() != 0) else begin
                    protocol_errs++;
                    $display("Result arrived with no request waiting for it");
                end
                if (exp_data_q.size() != 0) begin
                    exp_vd  = exp_data_q.pop_front();
                    exp_sat = exp_sat_q.pop_front();
                    name    = name_q.pop_front();
                    assert (res_data_o == exp_vd) else begin
                        value_errs++;
                        $display("Fail %s data: expected %h actual %h", name, exp_vd, res_data_o);
                    end
                    assert (res_sat_o == exp_sat) else begin
                        flag_errs++;
                        $display("Fail %s sat: expected %0b actual %0b", name, exp_sat, res_sat_o);
                    end
                end
                received++;
            end
            res_credit_i <= 1'b0;
            if (owed > 0 && $urandom_range(0, 1) == 1) begin
                res_credit_i <= 1'b1;
                owed--;
            end
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, results stopped arriving", cycles);
            report_counts();
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        arst_n_i     = 1'b1;
        run_en       = 1'b0;
        req_valid_i  = 1'b0;
        req_instr_i  = VSADDU;
        req_sew_i    = SEW_8;
        req_vxrm_i   = RNU_V;
        req_vs1_i    = '0;
        req_vs2_i    = '0;
        res_credit_i = 1'b0;
        vxsat_clr_i  = 1'b0;
        @(posedge clk_i);
        arst_n_i <= 1'b0;           // Falling edge starts the async reset
        repeat (5) @(posedge clk_i);
        arst_n_i <= 1'b1;
        run_en   <= 1'b1;
        wait (received >= NUM_REQ);
        repeat (4) @(posedge clk_i);
        assert (credit_pulses == NUM_REQ) else begin
            protocol_errs++;
            $display("Upstream got %0d credits back for %0d requests", credit_pulses, NUM_REQ);
        end
        assert (vxsat_o == 1'b0) else begin
            flag_errs++;
            $display("Fail vxsat after clear: expected 0 actual %0b", vxsat_o);
        end
        report_counts();
        if (value_errs + flag_errs + protocol_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
rtl/riscv_pkg.sv
rtl/drac_pkg.sv
rtl/vsaaddsub.sv
rtl/vfxp_issue_queue.sv
rtl/vfxp_writeback.sv
rtl/vfxp_unit.sv
dv/vfxp_unit_properties.sv
dv/vfxp_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the fixed-point unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -j 0 --top-module vfxp_unit_tb -f tb.f -o vfxp_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vfxp_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0
